/* hw/ddr2_ctrl_consts.svh */
// DDR2 controller widths and cycle timings, included by the RTL and the testbench
`ifndef DDR2_CTRL_CONSTS_SVH
`define DDR2_CTRL_CONSTS_SVH

// --------------------------------------------------
// address and data widths
// --------------------------------------------------
`define DDR_BA_BITS   3
`define DDR_ROW_BITS  14
`define DDR_COL_BITS  10
`define DDR_DQ_BITS   16
`define DDR_LEN_BITS  8

// beats per column command
`define DDR_BL        4

// --------------------------------------------------
// timings in controller clock cycles
// --------------------------------------------------
`define DDR_T_RCD     3
`define DDR_T_RP      3
`define DDR_T_RFC     26
// counted after the last write beat leaves DQ
`define DDR_T_WR      3
`define DDR_CL        3
// write latency is CL minus one
`define DDR_WL        2
`define DDR_T_REFI    1560
// CKE held low this long after reset
`define DDR_INIT_WAIT 200

`endif

/* hw/ddr2_ctrl_pkg.sv */
// shared DDR2 controller types, compiled before every module that imports them
`include "ddr2_ctrl_consts.svh"

package ddr2_ctrl_pkg;

  // encoded as {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP   = 4'b0111,
    CMD_PRE   = 4'b0010,
    CMD_AREF  = 4'b0001,
    CMD_ACT   = 4'b0011,
    CMD_WRITE = 4'b0100,
    CMD_READ  = 4'b0101
  } ddr_cmd_e;

  typedef enum logic [3:0] {
    S_INIT_WAIT,
    S_INIT_PRE,
    S_IDLE,
    S_ACTIVATE,
    S_WRITE,
    S_READ,
    S_OPEN,
    S_RECOVER,
    S_PRECHARGE,
    S_REFRESH
  } seq_state_e;

  // --------------------------------------------------
  // user address, seen as bank/row/col or as page/col
  // --------------------------------------------------
  typedef struct packed {
    logic [`DDR_BA_BITS-1:0]  ba;
    logic [`DDR_ROW_BITS-1:0] row;
    logic [`DDR_COL_BITS-1:0] col;
  } ddr_addr_fields_t;

  // page is bank and row together, for the open-page compare
  typedef struct packed {
    logic [`DDR_BA_BITS+`DDR_ROW_BITS-1:0] page;
    logic [`DDR_COL_BITS-1:0]              col;
  } ddr_addr_page_t;

  typedef union packed {
    ddr_addr_fields_t f;
    ddr_addr_page_t   p;
  } ddr_addr_u;

endpackage

/* hw/ddr2_beat_if.sv */
// strobes between the command sequencer and the write and read DQ paths
`timescale 1ns/1ps

interface ddr2_beat_if;

  // from the sequencer
  logic wr_take;
  logic wr_issue;
  logic rd_issue;
  logic rd_final;

  // back from the data paths
  logic wr_busy;
  logic rd_busy;

  modport seq (
    output wr_take, wr_issue, rd_issue, rd_final,
    input  wr_busy, rd_busy
  );

  modport data (
    input  wr_take, wr_issue, rd_issue, rd_final,
    output wr_busy, rd_busy
  );

endinterface

/* hw/ddr2_refresh_timer.sv */
// refresh interval counter that raises and holds the sequencer's refresh request
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_refresh_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic init_done,
  input  logic ref_ack,
  output logic ref_req
);

  localparam int CNT_W = $clog2(`DDR_T_REFI);

  logic [CNT_W-1:0] refi_cnt;
  logic             wrap;

  assign wrap = init_done && (refi_cnt == CNT_W'(`DDR_T_REFI - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refi_cnt <= '0;
      ref_req  <= 1'b0;
    end else begin
      if (wrap)
        refi_cnt <= '0;
      else if (init_done)
        refi_cnt <= refi_cnt + 1'b1;
      // a wrap while still pending just merges into it
      if (ref_ack)
        ref_req <= 1'b0;
      else if (wrap)
        ref_req <= 1'b1;
    end
  end

endmodule

/* hw/ddr2_cmd_sequencer.sv */
// DDR2 command FSM for init, refresh, activate, column commands and precharge
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_cmd_sequencer
  import ddr2_ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      awvalid,
  output logic                      awready,
  input  ddr_addr_u                 awaddr,
  input  logic [`DDR_LEN_BITS-1:0]  awlen,
  input  logic                      wvalid,
  output logic                      wready,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic                      arvalid,
  output logic                      arready,
  input  ddr_addr_u                 araddr,
  input  logic [`DDR_LEN_BITS-1:0]  arlen,
  input  logic                      ref_req,
  output logic                      ref_ack,
  output logic                      cke,
  output ddr_cmd_e                  cmd,
  output logic [`DDR_BA_BITS-1:0]   ba,
  output logic [`DDR_ROW_BITS-1:0]  addr,
  ddr2_beat_if.seq                  beat
);

  localparam int WAIT_W = $clog2(`DDR_INIT_WAIT);
  // A10 high selects all banks
  localparam logic [`DDR_ROW_BITS-1:0] PRE_ALL = `DDR_ROW_BITS'(1 << 10);

  seq_state_e                state;
  logic [WAIT_W-1:0]         wait_cnt;
  ddr_addr_u                 cur;
  ddr_addr_u                 req;
  logic [`DDR_LEN_BITS-1:0]  len;
  logic [`DDR_LEN_BITS:0]    beat_cnt;
  logic                      op_wr;
  logic                      cmd_final;
  logic                      can_take;
  logic                      aw_hit;
  logic                      ar_hit;
  logic                      wr_last;
  logic                      rd_last;
  logic [`DDR_ROW_BITS-1:0]  col_addr;

  // --------------------------------------------------
  // address acceptance and open-page compare
  // --------------------------------------------------
  assign req      = awvalid ? awaddr : araddr;
  assign aw_hit   = (awaddr.p.page == cur.p.page);
  assign ar_hit   = (araddr.p.page == cur.p.page);
  assign can_take = !ref_req && (state == S_IDLE || state == S_OPEN);
  assign awready  = can_take && (state == S_IDLE || aw_hit);
  // write wins when both are offered
  assign arready  = can_take && !awvalid && (state == S_IDLE || ar_hit);

  always_ff @(posedge clk) begin
    if ((awvalid && awready) || (arvalid && arready)) begin
      cur <= req;
      len <= awvalid ? awlen : arlen;
    end
  end

  // beat count and column of the next command
  assign wready   = (state == S_WRITE) && (beat_cnt <= {1'b0, len});
  assign wr_last  = (beat_cnt == {1'b0, len});
  assign rd_last  = (beat_cnt[`DDR_LEN_BITS:2] == {1'b0, len[`DDR_LEN_BITS-1:2]});
  assign col_addr = `DDR_ROW_BITS'(cur.f.col + `DDR_COL_BITS'({beat_cnt[`DDR_LEN_BITS:2], 2'b00}));

  assign beat.wr_take  = wready && wvalid;
  assign beat.wr_issue = (cmd == CMD_WRITE);
  assign beat.rd_issue = (cmd == CMD_READ);
  assign beat.rd_final = cmd_final;

  // --------------------------------------------------
  // main FSM, commands are registered onto the pins
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_INIT_WAIT;
      wait_cnt  <= WAIT_W'(`DDR_INIT_WAIT - 1);
      cke       <= 1'b0;
      cmd       <= CMD_NOP;
      ba        <= '0;
      addr      <= '0;
      beat_cnt  <= '0;
      op_wr     <= 1'b0;
      cmd_final <= 1'b0;
      bvalid    <= 1'b0;
      ref_ack   <= 1'b0;
    end else begin
      cmd       <= CMD_NOP;
      cmd_final <= 1'b0;
      ref_ack   <= 1'b0;
      if (wait_cnt != '0)
        wait_cnt <= wait_cnt - 1'b1;
      // response follows the final WRITE on the pins
      if (cmd == CMD_WRITE && cmd_final)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;

      case (state)
        S_INIT_WAIT: begin
          if (wait_cnt == '0) begin
            cke      <= 1'b1;
            cmd      <= CMD_PRE;
            addr     <= PRE_ALL;
            wait_cnt <= WAIT_W'(`DDR_T_RP - 1);
            state    <= S_INIT_PRE;
          end
        end
        S_INIT_PRE: begin
          if (wait_cnt == '0)
            state <= S_IDLE;
        end
        S_IDLE: begin
          if (ref_req) begin
            cmd      <= CMD_PRE;
            addr     <= PRE_ALL;
            wait_cnt <= WAIT_W'(`DDR_T_RP - 1);
            state    <= S_PRECHARGE;
          end else if (awvalid || arvalid) begin
            cmd      <= CMD_ACT;
            ba       <= req.f.ba;
            addr     <= req.f.row;
            op_wr    <= awvalid;
            beat_cnt <= '0;
            // READ lands exactly tRCD after ACT
            wait_cnt <= WAIT_W'(`DDR_T_RCD - 2);
            state    <= S_ACTIVATE;
          end
        end
        S_ACTIVATE: begin
          if (wait_cnt == '0)
            state <= op_wr ? S_WRITE : S_READ;
        end
        S_WRITE: begin
          if (beat.wr_take) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt[1:0] == 2'b11) begin
              cmd       <= CMD_WRITE;
              addr      <= col_addr;
              cmd_final <= wr_last;
            end
          end
          if (bvalid && bready)
            state <= S_OPEN;
        end
        S_READ: begin
          // wait_cnt keeps READs one burst apart, also across requests
          if (wait_cnt == '0) begin
            cmd       <= CMD_READ;
            addr      <= col_addr;
            cmd_final <= rd_last;
            beat_cnt  <= beat_cnt + `DDR_BL;
            wait_cnt  <= WAIT_W'(`DDR_BL - 1);
            if (rd_last)
              state <= S_OPEN;
          end
        end
        S_OPEN: begin
          if (awvalid && awready) begin
            beat_cnt <= '0;
            state    <= S_WRITE;
          end else if (arvalid && arready) begin
            beat_cnt <= '0;
            state    <= S_READ;
          end else if (ref_req || awvalid || arvalid) begin
            wait_cnt <= WAIT_W'(`DDR_T_WR - 1);
            state    <= S_RECOVER;
          end
        end
        S_RECOVER: begin
          // tWR restarts until both DQ paths are drained
          if (beat.wr_busy || beat.rd_busy) begin
            wait_cnt <= WAIT_W'(`DDR_T_WR - 1);
          end else if (wait_cnt == '0) begin
            cmd      <= CMD_PRE;
            addr     <= PRE_ALL;
            wait_cnt <= WAIT_W'(`DDR_T_RP - 1);
            state    <= S_PRECHARGE;
          end
        end
        S_PRECHARGE: begin
          if (wait_cnt == '0) begin
            if (ref_req) begin
              cmd      <= CMD_AREF;
              ref_ack  <= 1'b1;
              wait_cnt <= WAIT_W'(`DDR_T_RFC - 1);
              state    <= S_REFRESH;
            end else begin
              state <= S_IDLE;
            end
          end
        end
        S_REFRESH: begin
          if (wait_cnt == '0)
            state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

/* hw/ddr2_wr_datapath.sv */
// write path that gathers four beats and drives them onto DQ after write latency
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_wr_datapath (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`DDR_DQ_BITS-1:0]   wdata,
  output logic [`DDR_DQ_BITS-1:0]   dq_out,
  output logic                      dq_oe,
  output logic [`DDR_DQ_BITS/8-1:0] dqm,
  ddr2_beat_if.data                 beat
);

  localparam int IDX_W = $clog2(`DDR_BL);
  // gather to shifter load takes one cycle, the rest is this line
  localparam int DLY_W = `DDR_WL - 1;

  logic [`DDR_DQ_BITS-1:0] gather [`DDR_BL];
  logic [`DDR_DQ_BITS-1:0] grp    [`DDR_BL];
  logic [`DDR_DQ_BITS-1:0] sh     [`DDR_BL];
  logic [IDX_W-1:0]        g_idx;
  logic [DLY_W-1:0]        issue_dly;
  logic [IDX_W:0]          sh_left;
  logic                    load;

  assign load = issue_dly[DLY_W-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      g_idx     <= '0;
      issue_dly <= '0;
      sh_left   <= '0;
    end else begin
      if (beat.wr_take)
        g_idx <= g_idx + 1'b1;
      issue_dly <= DLY_W'({issue_dly, beat.wr_issue});
      if (load)
        sh_left <= (IDX_W + 1)'(`DDR_BL);
      else if (sh_left != '0)
        sh_left <= sh_left - 1'b1;
    end
  end

  // --------------------------------------------------
  // beat storage, gather then hold then shift out
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (beat.wr_take)
      gather[g_idx] <= wdata;
    if (beat.wr_issue)
      grp <= gather;
    if (load) begin
      sh <= grp;
    end else begin
      for (int i = 0; i < `DDR_BL - 1; i++)
        sh[i] <= sh[i + 1];
    end
  end

  assign dq_out = sh[0];
  assign dq_oe  = (sh_left != '0);
  assign dqm    = {(`DDR_DQ_BITS/8){~dq_oe}};

  // partial group, group waiting for its WRITE, or beats still queued
  assign beat.wr_busy = (g_idx != '0) | beat.wr_issue | (|issue_dly) | dq_oe;

endmodule

/* hw/ddr2_rd_capture.sv */
// read path that times READ bursts in flight and registers returning DQ beats
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_rd_capture (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`DDR_DQ_BITS-1:0] dq_in,
  output logic [`DDR_DQ_BITS-1:0] rdata,
  output logic                    rvalid,
  output logic                    rlast,
  ddr2_beat_if.data               beat
);

  localparam int WIN_W = $clog2(`DDR_BL);

  // one stage per cycle of CAS latency
  logic [`DDR_CL-1:0] rd_dly;
  logic [`DDR_CL-1:0] fin_dly;
  logic [WIN_W-1:0]   win_left;
  logic               win_fin;
  logic               win_start;
  logic               win_open;

  assign win_start = rd_dly[`DDR_CL-1];
  assign win_open  = win_start | (win_left != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_dly   <= '0;
      fin_dly  <= '0;
      win_left <= '0;
      win_fin  <= 1'b0;
      rvalid   <= 1'b0;
      rlast    <= 1'b0;
    end else begin
      rd_dly  <= {rd_dly[`DDR_CL-2:0], beat.rd_issue};
      fin_dly <= {fin_dly[`DDR_CL-2:0], beat.rd_issue & beat.rd_final};
      // first beat is on dq_in when the line ends
      if (win_start) begin
        win_left <= WIN_W'(`DDR_BL - 1);
        win_fin  <= fin_dly[`DDR_CL-1];
      end else if (win_left != '0) begin
        win_left <= win_left - 1'b1;
      end
      rvalid <= win_open;
      rlast  <= !win_start && (win_left == WIN_W'(1)) && win_fin;
    end
  end

  always_ff @(posedge clk) begin
    if (win_open)
      rdata <= dq_in;
  end

  assign beat.rd_busy = beat.rd_issue | (|rd_dly) | (win_left != '0);

endmodule

/* hw/ddr2_ctrl_top.sv */
// DDR2 controller top level, the DUT that the testbench instantiates
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_ctrl_top
  import ddr2_ctrl_pkg::*;
(
  input  logic                                        clk,
  input  logic                                        rst_n,
  // write address, data and response
  input  logic                                        awvalid,
  output logic                                        awready,
  input  logic [`DDR_BA_BITS+`DDR_ROW_BITS+`DDR_COL_BITS-1:0] awaddr,
  input  logic [`DDR_LEN_BITS-1:0]                    awlen,
  input  logic                                        wvalid,
  output logic                                        wready,
  input  logic [`DDR_DQ_BITS-1:0]                     wdata,
  output logic                                        bvalid,
  input  logic                                        bready,
  // read address and data
  input  logic                                        arvalid,
  output logic                                        arready,
  input  logic [`DDR_BA_BITS+`DDR_ROW_BITS+`DDR_COL_BITS-1:0] araddr,
  input  logic [`DDR_LEN_BITS-1:0]                    arlen,
  output logic                                        rvalid,
  output logic                                        rlast,
  output logic [`DDR_DQ_BITS-1:0]                     rdata,
  // DDR2 pins
  output logic                                        ddr2_cke,
  output logic                                        ddr2_cs_n,
  output logic                                        ddr2_ras_n,
  output logic                                        ddr2_cas_n,
  output logic                                        ddr2_we_n,
  output logic [`DDR_BA_BITS-1:0]                     ddr2_ba,
  output logic [`DDR_ROW_BITS-1:0]                    ddr2_addr,
  output logic [`DDR_DQ_BITS-1:0]                     ddr2_dq_out,
  output logic                                        ddr2_dq_oe,
  output logic [`DDR_DQ_BITS/8-1:0]                   ddr2_dqm,
  input  logic [`DDR_DQ_BITS-1:0]                     ddr2_dq_in
);

  ddr_cmd_e cmd;
  logic     ref_req;
  logic     ref_ack;

  ddr2_beat_if beat ();

  assign {ddr2_cs_n, ddr2_ras_n, ddr2_cas_n, ddr2_we_n} = cmd;

  ddr2_cmd_sequencer i_cmd_sequencer (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .arlen   (arlen),
    .ref_req (ref_req),
    .ref_ack (ref_ack),
    .cke     (ddr2_cke),
    .cmd     (cmd),
    .ba      (ddr2_ba),
    .addr    (ddr2_addr),
    .beat    (beat.seq)
  );

  // refresh interval starts once CKE is up
  ddr2_refresh_timer i_refresh_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .init_done (ddr2_cke),
    .ref_ack   (ref_ack),
    .ref_req   (ref_req)
  );

  ddr2_wr_datapath i_wr_datapath (
    .clk    (clk),
    .rst_n  (rst_n),
    .wdata  (wdata),
    .dq_out (ddr2_dq_out),
    .dq_oe  (ddr2_dq_oe),
    .dqm    (ddr2_dqm),
    .beat   (beat.data)
  );

  ddr2_rd_capture i_rd_capture (
    .clk    (clk),
    .rst_n  (rst_n),
    .dq_in  (ddr2_dq_in),
    .rdata  (rdata),
    .rvalid (rvalid),
    .rlast  (rlast),
    .beat   (beat.data)
  );

endmodule

/* dv/ddr2_ctrl_properties.sv */
// command spacing assertions on the DDR2 pins, bound into the controller top level
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_ctrl_properties
  import ddr2_ctrl_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic cs_n,
  input logic ras_n,
  input logic cas_n,
  input logic we_n
);

  ddr_cmd_e cmd;
  logic     col_cmd;
  // failed assertions so far, for the end of run summary
  int       fail_cnt = 0;

  assign cmd     = ddr_cmd_e'({cs_n, ras_n, cas_n, we_n});
  assign col_cmd = (cmd == CMD_WRITE) || (cmd == CMD_READ);

  // --------------------------------------------------
  // minimum spacing after ACT, PRE and AREF
  // --------------------------------------------------
  act_to_col: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cmd == CMD_ACT) |=> (!col_cmd) [*(`DDR_T_RCD-1)]
  ) else begin
    $error("column command issued sooner than tRCD after ACT");
    fail_cnt++;
  end

  pre_to_next: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cmd == CMD_PRE) |=> (cmd == CMD_NOP) [*(`DDR_T_RP-1)]
  ) else begin
    $error("command issued sooner than tRP after PRE");
    fail_cnt++;
  end

  // AREF blocks every command for the whole tRFC
  aref_to_next: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cmd == CMD_AREF) |=> (cmd == CMD_NOP) [*(`DDR_T_RFC-1)]
  ) else begin
    $error("command issued sooner than tRFC after AREF");
    fail_cnt++;
  end

endmodule

bind ddr2_ctrl_top ddr2_ctrl_properties i_props (
  .clk   (clk),
  .rst_n (rst_n),
  .cs_n  (ddr2_cs_n),
  .ras_n (ddr2_ras_n),
  .cas_n (ddr2_cas_n),
  .we_n  (ddr2_we_n)
);

/* dv/ddr2_ctrl_tb.sv */
// DDR2 controller testbench with memory model, run as the simulation top
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_ctrl_tb
  import ddr2_ctrl_pkg::*;
();

  localparam int AW         = `DDR_BA_BITS + `DDR_ROW_BITS + `DDR_COL_BITS;
  localparam int CLK_HALF   = 10;
  localparam int SLOTS      = 16;
  // generous cycle budget for one write or read request
  localparam int REQ_BUDGET = 200;
  localparam int N_REQ      = 36;
  // init, all requests, refresh wait and idle window, two spare intervals
  localparam int WD_CYCLES  = `DDR_INIT_WAIT + N_REQ * REQ_BUDGET + 6 * `DDR_T_REFI;

  logic                      clk;
  logic                      rst_n;
  logic                      awvalid;
  logic                      awready;
  ddr_addr_u                 awaddr;
  logic [`DDR_LEN_BITS-1:0]  awlen;
  logic                      wvalid;
  logic                      wready;
  logic [`DDR_DQ_BITS-1:0]   wdata;
  logic                      bvalid;
  logic                      bready;
  logic                      arvalid;
  logic                      arready;
  ddr_addr_u                 araddr;
  logic [`DDR_LEN_BITS-1:0]  arlen;
  logic                      rvalid;
  logic                      rlast;
  logic [`DDR_DQ_BITS-1:0]   rdata;
  logic                      ddr2_cke;
  logic                      ddr2_cs_n;
  logic                      ddr2_ras_n;
  logic                      ddr2_cas_n;
  logic                      ddr2_we_n;
  logic [`DDR_BA_BITS-1:0]   ddr2_ba;
  logic [`DDR_ROW_BITS-1:0]  ddr2_addr;
  logic [`DDR_DQ_BITS-1:0]   ddr2_dq_out;
  logic                      ddr2_dq_oe;
  logic [`DDR_DQ_BITS/8-1:0] ddr2_dqm;
  logic [`DDR_DQ_BITS-1:0]   ddr2_dq_in;
  ddr_cmd_e                  pin_cmd;

  // bookkeeping
  string                   cur_test;
  int                      test_err0;
  int                      n_tests;
  int                      n_passed;
  int                      n_checks;
  int                      n_err;
  int                      n_act;
  int                      n_pre;
  int                      n_aref;
  int                      n_brise;
  int                      cyc;
  int                      last_pre_cyc;
  int                      last_act_cyc;
  logic [`DDR_DQ_BITS-1:0] exp_data_q [$];
  bit                      exp_last_q [$];
  ddr_addr_u               done_addr_q [$];
  int                      done_len_q [$];

  // memory model state
  logic [`DDR_DQ_BITS-1:0]  mem [int];
  logic [`DDR_ROW_BITS-1:0] open_row [1 << `DDR_BA_BITS];
  bit                       ws_v [SLOTS];
  logic [AW-1:0]            ws_a [SLOTS];
  bit                       rs_v [SLOTS];
  logic [AW-1:0]            rs_a [SLOTS];

  assign pin_cmd = ddr_cmd_e'({ddr2_cs_n, ddr2_ras_n, ddr2_cas_n, ddr2_we_n});

  ddr2_ctrl_top i_ddr2_ctrl_top (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  initial begin
    #(WD_CYCLES * 2 * CLK_HALF);
    $display("timeout: run did not finish within %0d cycles", WD_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  // --------------------------------------------------
  // reference data and result checks
  // --------------------------------------------------
  // expected word for beat of a request, also used as the write data
  function automatic logic [`DDR_DQ_BITS-1:0] ref_data(ddr_addr_u base, int beat);
    logic [AW-1:0] w;
    w = AW'(base) + AW'(beat);
    return w[15:0] ^ {w[AW-1:16], 5'b10110} ^ 16'h3c5a;
  endfunction

  // unwritten locations read back as a pattern of the whole address
  function automatic logic [`DDR_DQ_BITS-1:0] mem_word(logic [AW-1:0] key);
    if (mem.exists(int'(key)))
      return mem[int'(key)];
    return key[15:0] ^ {5'b0, key[AW-1:16]};
  endfunction

  task automatic check_data(input string what, input logic [`DDR_DQ_BITS-1:0] exp,
                            input logic [`DDR_DQ_BITS-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_err++;
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_cmd(input string what, input ddr_cmd_e exp, input ddr_cmd_e act);
    n_checks++;
    if (act !== exp) begin
      n_err++;
      $display("ERR %s %s: expected %s, actual %s", cur_test, what, exp.name(), act.name());
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
      n_err++;
      $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    n_err++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = n_err;
  endtask

  task automatic end_test();
    n_tests++;
    if (n_err == test_err0) begin
      n_passed++;
      $display("test %-8s ok", cur_test);
    end else begin
      $display("test %-8s %0d errors", cur_test, n_err - test_err0);
    end
  endtask

  // --------------------------------------------------
  // DDR2 pin model, command counters and write capture
  // --------------------------------------------------
  always @(negedge clk) begin : pin_model
    int            slot;
    logic [AW-1:0] key;
    ddr_cmd_e      prev_cmd;
    logic          prev_a10;
    logic          bvalid_q;
    cyc++;
    slot = cyc % SLOTS;
    if (rst_n) begin
      if (bvalid && !bvalid_q)
        n_brise++;
      bvalid_q = bvalid;
      key = {ddr2_ba, open_row[ddr2_ba], ddr2_addr[`DDR_COL_BITS-1:0]};
      case (pin_cmd)
        CMD_ACT: begin
          open_row[ddr2_ba] = ddr2_addr;
          n_act++;
          last_act_cyc = cyc;
        end
        CMD_PRE: begin
          n_pre++;
          last_pre_cyc = cyc;
        end
        CMD_AREF: begin
          n_aref++;
          if (prev_cmd != CMD_PRE || !prev_a10)
            note_failure("AREF was not preceded by a precharge of all banks");
        end
        CMD_WRITE: begin
          for (int k = 0; k < `DDR_BL; k++) begin
            ws_v[(cyc + `DDR_WL + k) % SLOTS] = 1'b1;
            ws_a[(cyc + `DDR_WL + k) % SLOTS] = key + AW'(k);
          end
        end
        CMD_READ: begin
          for (int k = 0; k < `DDR_BL; k++) begin
            rs_v[(cyc + `DDR_CL + k) % SLOTS] = 1'b1;
            rs_a[(cyc + `DDR_CL + k) % SLOTS] = key + AW'(k);
          end
        end
        default: ;
      endcase
      if (pin_cmd != CMD_NOP) begin
        prev_cmd = pin_cmd;
        prev_a10 = ddr2_addr[10];
      end
      if (ws_v[slot]) begin
        check_count("dq_oe", 1, int'(ddr2_dq_oe));
        check_count("dqm", 0, int'(ddr2_dqm));
        mem[int'(ws_a[slot])] = ddr2_dq_out;
        ws_v[slot] = 1'b0;
      end else if (ddr2_dq_oe) begin
        note_failure("DQ driven in a cycle with no write beat due");
      end
      ddr2_dq_in = '0;
      if (rs_v[slot]) begin
        ddr2_dq_in = mem_word(rs_a[slot]);
        rs_v[slot] = 1'b0;
      end
    end
  end

  // every returned read beat against the reference
  always @(negedge clk) begin : compare
    if (rst_n && rvalid) begin
      if (exp_data_q.size() == 0) begin
        note_failure("rvalid high with no read beat outstanding");
      end else begin
        check_data("rdata", exp_data_q.pop_front(), rdata);
        check_count("rlast", int'(exp_last_q.pop_front()), int'(rlast));
      end
    end
  end

  // --------------------------------------------------
  // request drivers
  // --------------------------------------------------
  function automatic ddr_addr_u rand_addr();
    ddr_addr_u a;
    a.f.ba  = `DDR_BA_BITS'($urandom);
    a.f.row = `DDR_ROW_BITS'($urandom);
    a.f.col = `DDR_COL_BITS'(4 * ($urandom % 253));
    return a;
  endfunction

  function automatic int rand_len();
    case ($urandom % 3)
      0:       return 4;
      1:       return 8;
      default: return 16;
    endcase
  endfunction

  task automatic send_aw(input ddr_addr_u a, input int nbeats);
    @(negedge clk);
    awvalid = 1'b1;
    awaddr  = a;
    awlen   = `DDR_LEN_BITS'(nbeats - 1);
    #1;
    while (!awready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    awvalid = 1'b0;
  endtask

  task automatic send_ar(input ddr_addr_u a, input int nbeats);
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = a;
    arlen   = `DDR_LEN_BITS'(nbeats - 1);
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  // holds bready low a random while, then takes the response
  task automatic take_response(input int hold_max);
    int hold;
    while (!bvalid)
      @(negedge clk);
    hold = $urandom % (hold_max + 1);
    repeat (hold) begin
      @(negedge clk);
      check_count("bvalid_held", 1, int'(bvalid));
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    check_count("bvalid_cleared", 0, int'(bvalid));
  endtask

  task automatic do_write(input ddr_addr_u a, input int nbeats, input int hold_max);
    int gap;
    send_aw(a, nbeats);
    for (int i = 0; i < nbeats; i++) begin
      gap = $urandom % 3;
      repeat (gap) @(negedge clk);
      wvalid = 1'b1;
      wdata  = ref_data(a, i);
      #1;
      while (!wready) begin
        @(negedge clk);
        #1;
      end
      @(negedge clk);
      wvalid = 1'b0;
    end
    take_response(hold_max);
    done_addr_q.push_back(a);
    done_len_q.push_back(nbeats);
  endtask

  task automatic do_read(input ddr_addr_u a, input int nbeats);
    int seen;
    bit got_last;
    for (int i = 0; i < nbeats; i++) begin
      exp_data_q.push_back(ref_data(a, i));
      exp_last_q.push_back(i == nbeats - 1);
    end
    send_ar(a, nbeats);
    // count beats up to the one flagged rlast
    seen     = 0;
    got_last = 1'b0;
    while (!got_last) begin
      @(negedge clk);
      if (rvalid) begin
        seen++;
        got_last = rlast;
      end
    end
    check_count("rvalid_beats", nbeats, seen);
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic test_init();
    int n;
    begin_test("init");
    n = 0;
    while (pin_cmd == CMD_NOP && n <= `DDR_INIT_WAIT + 10) begin
      if (ddr2_cke || awready || arready || wready || bvalid || rvalid)
        note_failure("CKE or a user handshake output went high before init finished");
      n++;
      @(negedge clk);
    end
    check_count("init_nop_cycles", `DDR_INIT_WAIT, n);
    check_cmd("init_first_cmd", CMD_PRE, pin_cmd);
    check_count("init_pre_a10", 1, int'(ddr2_addr[10]));
    check_count("init_cke", 1, int'(ddr2_cke));
    end_test();
  endtask

  task automatic test_write_read();
    ddr_addr_u a;
    int        len;
    begin_test("wr_rd");
    repeat (6) begin
      a   = rand_addr();
      len = rand_len();
      do_write(a, len, 2);
      do_read(a, len);
    end
    end_test();
  endtask

  task automatic test_page_hit();
    ddr_addr_u a;
    ddr_addr_u b;
    int        act0;
    int        pre0;
    int        aref0;
    begin_test("page_hit");
    // start just after a refresh so none falls inside the window
    aref0 = n_aref;
    while (n_aref == aref0)
      @(negedge clk);
    a       = rand_addr();
    b       = a;
    b.f.row = a.f.row + 1'b1;
    do_write(a, 8, 2);
    act0 = n_act;
    pre0 = n_pre;
    do_read(a, 8);
    check_count("hit_act", 0, n_act - act0);
    check_count("hit_pre", 0, n_pre - pre0);
    act0 = n_act;
    pre0 = n_pre;
    do_write(b, 8, 2);
    check_count("miss_act", 1, n_act - act0);
    check_count("miss_pre", 1, n_pre - pre0);
    if (last_pre_cyc >= last_act_cyc)
      note_failure("row miss did not issue PRE before ACT");
    act0 = n_act;
    pre0 = n_pre;
    do_read(b, 4);
    check_count("hit_act", 0, n_act - act0);
    check_count("hit_pre", 0, n_pre - pre0);
    end_test();
  endtask

  task automatic test_write_resp();
    int b0;
    begin_test("wr_resp");
    b0 = n_brise;
    repeat (4)
      do_write(rand_addr(), rand_len(), 8);
    check_count("bvalid_rises", 4, n_brise - b0);
    end_test();
  endtask

  task automatic test_refresh();
    int aref0;
    int seen;
    begin_test("refresh");
    aref0 = n_aref;
    repeat (3 * `DDR_T_REFI) @(negedge clk);
    seen = n_aref - aref0;
    if (seen < 2 || seen > 4)
      note_failure($sformatf("%0d AREF commands in three refresh intervals, not 2 to 4",
                             seen));
    end_test();
  endtask

  task automatic test_mixed();
    int idx;
    begin_test("mixed");
    repeat (16) begin
      if (done_addr_q.size() == 0 || ($urandom % 2) == 0) begin
        do_write(rand_addr(), rand_len(), 2);
      end else begin
        idx = $urandom % done_addr_q.size();
        do_read(done_addr_q[idx], done_len_q[idx]);
      end
    end
    check_count("assertion_failures", 0, i_ddr2_ctrl_top.i_props.fail_cnt);
    end_test();
  endtask

  initial begin
    int asrt;
    void'($urandom(32'h3e266751));
    rst_n      = 1'b0;
    awvalid    = 1'b0;
    awaddr     = '0;
    awlen      = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = '0;
    arlen      = '0;
    ddr2_dq_in = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    test_init();
    test_write_read();
    test_page_hit();
    test_write_resp();
    test_refresh();
    test_mixed();
    repeat (20) @(negedge clk);
    asrt = i_ddr2_ctrl_top.i_props.fail_cnt;
    $display("summary: %0d tests, %0d passed, %0d checks, %0d errors, %0d assertion failures",
             n_tests, n_passed, n_checks, n_err, asrt);
    if (n_err == 0 && asrt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hw
hw/ddr2_ctrl_pkg.sv
hw/ddr2_beat_if.sv
hw/ddr2_refresh_timer.sv
hw/ddr2_cmd_sequencer.sv
hw/ddr2_wr_datapath.sv
hw/ddr2_rd_capture.sv
hw/ddr2_ctrl_top.sv
dv/ddr2_ctrl_properties.sv
dv/ddr2_ctrl_tb.sv
